/* filelist.f */
logic/rifl_tx_pkg.sv
logic/tx_replay_if.sv
logic/tx_state_ctrl.sv
logic/retrans_buffer.sv
logic/frame_assembler.sv
logic/crc12_gen.sv
logic/rifl_tx_lane.sv
verification/rifl_tx_lane_assert.sv
verification/tb_rifl_tx_lane.sv

/* logic/crc12_gen.sv */
// crc-12 over code and payload, msb first, initial value zero
// the whole frame is registered, one cycle of latency
module crc12_gen
    import rifl_tx_pkg::*;
(
    input  logic                                tx_frame_clk,
    input  logic                                rst_n,
    input  logic [CODE_WIDTH+PAYLOAD_WIDTH-1:0] frame_body,
    output frame_t                              tx_frame
);
    logic [CRC_WIDTH-1:0] crc;

    // serial lfsr, unrolled over all body bits
    function automatic logic [CRC_WIDTH-1:0] calc_crc12(
        input logic [CODE_WIDTH+PAYLOAD_WIDTH-1:0] body
    );
        logic [CRC_WIDTH-1:0] acc;
        logic                 fb;
        acc = '0;
        for (int i = CODE_WIDTH + PAYLOAD_WIDTH - 1; i >= 0; i--) begin
            fb  = acc[CRC_WIDTH-1] ^ body[i];
            acc = {acc[CRC_WIDTH-2:0], 1'b0};
            if (fb) begin
                acc = acc ^ CRC_POLY;
            end
        end
        return acc;
    endfunction

    assign crc = calc_crc12(frame_body);

    always_ff @(posedge tx_frame_clk) begin
        if (!rst_n) begin
            tx_frame <= '0;
        end else begin
            tx_frame <= {frame_body, crc};
        end
    end

endmodule

/* logic/frame_assembler.sv */
// header code and payload field of the next frame, crc is added downstream
module frame_assembler
    import rifl_tx_pkg::*;
(
    input  frame_kind_t                           frame_kind,
    input  payload_t                              s_axis_tdata,
    input  logic                                  s_axis_tlast,
    tx_replay_if.assembler                        replay,
    output logic [CODE_WIDTH+PAYLOAD_WIDTH-1:0]   frame_body
);
    frame_code_t code;
    payload_t    field;

    always_comb begin
        code  = CODE_IDLE;
        // control frames report the next id by default
        field = payload_t'(replay.next_id);
        case (frame_kind)
            KIND_INIT: begin
                code = CODE_INIT;
            end
            KIND_IDLE: begin
                code = CODE_IDLE;
            end
            KIND_PAUSE: begin
                code = CODE_PAUSE;
            end
            KIND_RETRANS: begin
                code  = CODE_RETRANS;
                field = payload_t'(replay.start_id);
            end
            KIND_USER: begin
                code  = s_axis_tlast ? CODE_DATA_LAST : CODE_DATA;
                field = s_axis_tdata;
            end
            KIND_REPLAY: begin
                code  = replay.replay_last ? CODE_DATA_LAST : CODE_DATA;
                field = replay.replay_payload;
            end
            default: begin
                code = CODE_IDLE;
            end
        endcase
    end

    assign frame_body = {code, field};

endmodule

/* logic/retrans_buffer.sv */
// keeps every sent data frame until its id wraps around
// no flow control against overwrite, the far end must ask within 64 frames
module retrans_buffer
    import rifl_tx_pkg::*;
(
    input  logic         tx_frame_clk,
    input  logic         rst_n,
    input  payload_t     s_axis_tdata,
    input  logic         s_axis_tlast,
    tx_replay_if.buffer  replay
);
    payload_t  mem_payload [2**FRAME_ID_WIDTH];
    logic      mem_last    [2**FRAME_ID_WIDTH];
    frame_id_t wr_id;
    frame_id_t rd_ptr;

    // id counter survives alignment loss, only reset clears it
    always_ff @(posedge tx_frame_clk) begin
        if (!rst_n) begin
            wr_id <= '0;
        end else if (replay.store) begin
            wr_id <= wr_id + 1'b1;
        end
    end

    always_ff @(posedge tx_frame_clk) begin
        if (replay.store) begin
            mem_payload[wr_id] <= s_axis_tdata;
            mem_last[wr_id]    <= s_axis_tlast;
        end
    end

    // read pointer for the replay
    always_ff @(posedge tx_frame_clk) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (replay.start) begin
            rd_ptr <= replay.start_id;
        end else if (replay.advance) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    assign replay.next_id        = wr_id;
    assign replay.replay_payload = mem_payload[rd_ptr];
    assign replay.replay_last    = mem_last[rd_ptr];
    // caught up with the newest frame
    assign replay.replay_done    = (rd_ptr == wr_id);

endmodule

/* logic/rifl_tx_lane.sv */
// transmit side of one lane, everything on tx_frame_clk
// request levels come from the far end receiver, one frame leaves every clock
module rifl_tx_lane
    import rifl_tx_pkg::*;
(
    input  logic      tx_frame_clk,
    input  logic      rst_n,
    input  logic      rx_aligned,
    input  logic      pause_request,
    input  logic      retrans_request,
    input  frame_id_t retrans_id,
    input  payload_t  s_axis_tdata,
    input  logic      s_axis_tlast,
    input  logic      s_axis_tvalid,
    output logic      s_axis_tready,
    output frame_t    tx_frame,
    output logic      tx_state_init,
    output logic      tx_state_send_pause,
    output logic      tx_state_pause,
    output logic      tx_state_send_retrans,
    output logic      tx_state_retrans,
    output logic      tx_state_normal
);
    tx_state_t                           state;
    frame_kind_t                         frame_kind;
    logic [CODE_WIDTH+PAYLOAD_WIDTH-1:0] frame_body;

    tx_replay_if replay_bus ();

    tx_state_ctrl u_tx_state_ctrl (
        .tx_frame_clk    (tx_frame_clk),
        .rst_n           (rst_n),
        .rx_aligned      (rx_aligned),
        .pause_request   (pause_request),
        .retrans_request (retrans_request),
        .retrans_id      (retrans_id),
        .s_axis_tvalid   (s_axis_tvalid),
        .s_axis_tready   (s_axis_tready),
        .state           (state),
        .frame_kind      (frame_kind),
        .replay          (replay_bus.ctrl)
    );

    retrans_buffer u_retrans_buffer (
        .tx_frame_clk (tx_frame_clk),
        .rst_n        (rst_n),
        .s_axis_tdata (s_axis_tdata),
        .s_axis_tlast (s_axis_tlast),
        .replay       (replay_bus.buffer)
    );

    frame_assembler u_frame_assembler (
        .frame_kind   (frame_kind),
        .s_axis_tdata (s_axis_tdata),
        .s_axis_tlast (s_axis_tlast),
        .replay       (replay_bus.assembler),
        .frame_body   (frame_body)
    );

    crc12_gen u_crc12_gen (
        .tx_frame_clk (tx_frame_clk),
        .rst_n        (rst_n),
        .frame_body   (frame_body),
        .tx_frame     (tx_frame)
    );

    // status flags, one per state
    assign tx_state_init         = (state == ST_INIT);
    assign tx_state_send_pause   = (state == ST_SEND_PAUSE);
    assign tx_state_pause        = (state == ST_PAUSE);
    assign tx_state_send_retrans = (state == ST_SEND_RETRANS);
    assign tx_state_retrans      = (state == ST_RETRANS);
    assign tx_state_normal       = (state == ST_NORMAL);

endmodule

/* logic/rifl_tx_pkg.sv */
// shared widths, codes and types for the single-lane transmit path
// frame layout is fixed at 64 bits: code, payload field, crc from the top down
package rifl_tx_pkg;

    localparam int FRAME_WIDTH    = 64;
    localparam int CODE_WIDTH     = 4;
    localparam int CRC_WIDTH      = 12;
    localparam logic [CRC_WIDTH-1:0] CRC_POLY = 12'h02F;
    localparam int PAYLOAD_WIDTH  = FRAME_WIDTH - CODE_WIDTH - CRC_WIDTH;
    // one buffer entry per id, 64 entries
    localparam int FRAME_ID_WIDTH = 6;

    typedef logic [PAYLOAD_WIDTH-1:0]  payload_t;
    typedef logic [FRAME_WIDTH-1:0]    frame_t;
    typedef logic [FRAME_ID_WIDTH-1:0] frame_id_t;

    // header codes as seen on the wire
    typedef enum logic [CODE_WIDTH-1:0] {
        CODE_INIT      = 4'd1,
        CODE_IDLE      = 4'd2,
        CODE_DATA      = 4'd3,
        CODE_DATA_LAST = 4'd4,
        CODE_PAUSE     = 4'd5,
        CODE_RETRANS   = 4'd6
    } frame_code_t;

    // encoding matches the status flags of the full link layer
    typedef enum logic [2:0] {
        ST_INIT         = 3'd0,
        ST_SEND_PAUSE   = 3'd1,
        ST_PAUSE        = 3'd2,
        ST_RETRANS      = 3'd3,
        ST_SEND_RETRANS = 3'd4,
        ST_NORMAL       = 3'd5
    } tx_state_t;

    // what the controller wants on the wire this cycle
    typedef enum logic [2:0] {
        KIND_INIT,
        KIND_IDLE,
        KIND_PAUSE,
        KIND_RETRANS,
        KIND_USER,
        KIND_REPLAY
    } frame_kind_t;

endpackage

/* logic/tx_replay_if.sv */
// replay control between the transmit FSM, the retransmission buffer and the assembler
// all signals are in the tx_frame_clk domain, pulses last one cycle
interface tx_replay_if
    import rifl_tx_pkg::*;
();
    logic      store;
    logic      start;
    frame_id_t start_id;
    logic      advance;
    frame_id_t next_id;
    payload_t  replay_payload;
    logic      replay_last;
    logic      replay_done;

    modport ctrl (
        output store, start, start_id, advance,
        input  replay_done
    );

    modport buffer (
        input  store, start, start_id, advance,
        output next_id, replay_payload, replay_last, replay_done
    );

    // retrans frames also carry the requested id
    modport assembler (
        input next_id, replay_payload, replay_last, start_id
    );

endinterface

/* logic/tx_state_ctrl.sv */
// transmit FSM, one decision per frame clock
// frame_kind and the replay pulses are combinational from state and the request levels
module tx_state_ctrl
    import rifl_tx_pkg::*;
(
    input  logic        tx_frame_clk,
    input  logic        rst_n,
    input  logic        rx_aligned,
    input  logic        pause_request,
    input  logic        retrans_request,
    input  frame_id_t   retrans_id,
    input  logic        s_axis_tvalid,
    output logic        s_axis_tready,
    output tx_state_t   state,
    output frame_kind_t frame_kind,
    tx_replay_if.ctrl   replay
);
    tx_state_t state_next;

    // user beats only in a clean normal cycle
    assign s_axis_tready = (state == ST_NORMAL) && rx_aligned
                           && !pause_request && !retrans_request;

    always_ff @(posedge tx_frame_clk) begin
        if (!rst_n) begin
            state <= ST_INIT;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next      = state;
        frame_kind      = KIND_IDLE;
        replay.store    = 1'b0;
        replay.start    = 1'b0;
        replay.start_id = retrans_id;
        replay.advance  = 1'b0;

        // lost alignment overrides everything
        if (!rx_aligned) begin
            state_next = ST_INIT;
            frame_kind = KIND_INIT;
        end else begin
            case (state)
                ST_INIT: begin
                    state_next = ST_NORMAL;
                end
                ST_NORMAL: begin
                    if (retrans_request) begin
                        state_next = ST_SEND_RETRANS;
                    end else if (pause_request) begin
                        state_next = ST_SEND_PAUSE;
                    end else if (s_axis_tvalid && s_axis_tready) begin
                        frame_kind   = KIND_USER;
                        replay.store = 1'b1;
                    end
                end
                ST_SEND_PAUSE: begin
                    frame_kind = KIND_PAUSE;
                    state_next = ST_PAUSE;
                end
                ST_PAUSE: begin
                    // a retransmission request beats the pause
                    if (retrans_request) begin
                        state_next = ST_SEND_RETRANS;
                    end else if (!pause_request) begin
                        state_next = ST_NORMAL;
                    end
                end
                ST_SEND_RETRANS: begin
                    frame_kind   = KIND_RETRANS;
                    replay.start = 1'b1;
                    state_next   = ST_RETRANS;
                end
                ST_RETRANS: begin
                    if (replay.replay_done) begin
                        state_next = ST_NORMAL;
                    end else begin
                        frame_kind     = KIND_REPLAY;
                        replay.advance = 1'b1;
                    end
                end
                default: begin
                    state_next = ST_INIT;
                    frame_kind = KIND_INIT;
                end
            endcase
        end
    end

endmodule

/* verification/rifl_tx_lane_assert.sv */
// concurrent checks on the transmit FSM status outputs, bound to the lane top level
// checks are off while rst_n is low
module rifl_tx_lane_assert (
    input logic tx_frame_clk,
    input logic rst_n,
    input logic s_axis_tready,
    input logic tx_state_init,
    input logic tx_state_send_pause,
    input logic tx_state_pause,
    input logic tx_state_send_retrans,
    input logic tx_state_retrans,
    input logic tx_state_normal
);
    // number of failed assertions, read by the testbench
    int unsigned fail_count;

    initial begin
        fail_count = 0;
    end

    // user beats are only taken in normal
    a_ready_in_normal: assert property (@(posedge tx_frame_clk) disable iff (!rst_n)
        s_axis_tready |-> tx_state_normal)
        else begin
            $error("s_axis_tready is high outside the normal state");
            fail_count++;
        end

    a_flags_one_hot: assert property (@(posedge tx_frame_clk) disable iff (!rst_n)
        $onehot({tx_state_init, tx_state_send_pause, tx_state_pause,
                 tx_state_send_retrans, tx_state_retrans, tx_state_normal}))
        else begin
            $error("the state flags are not one-hot");
            fail_count++;
        end

    // single pause frame
    a_send_pause_once: assert property (@(posedge tx_frame_clk) disable iff (!rst_n)
        tx_state_send_pause |=> !tx_state_send_pause)
        else begin
            $error("send_pause lasted longer than one cycle");
            fail_count++;
        end

    // single retrans frame
    a_send_retrans_once: assert property (@(posedge tx_frame_clk) disable iff (!rst_n)
        tx_state_send_retrans |=> !tx_state_send_retrans)
        else begin
            $error("send_retrans lasted longer than one cycle");
            fail_count++;
        end

endmodule

/* verification/rifl_tx_trace.txt */
// columns: rx_aligned pause_request retrans_request retrans_id tvalid tdata tlast
//          then expected tready, expected state, and code and payload of the frame one cycle later
// init, alignment, data beats with tlast
0 0 0 00 0 000000000000 0 0 0 1 000000000000
1 0 0 00 0 000000000000 0 0 0 2 000000000000
1 0 0 00 1 a5a500000000 0 1 5 3 a5a500000000
1 0 0 00 1 0123456789ab 1 1 5 4 0123456789ab
1 0 0 00 0 000000000000 0 1 5 2 000000000002
1 0 0 00 1 fedcba987654 0 1 5 3 fedcba987654
1 0 0 00 1 5a5a5a5a5a5a 1 1 5 4 5a5a5a5a5a5a
1 0 0 00 0 000000000000 0 1 5 2 000000000004
// pause with a beat held valid
1 1 0 00 1 00000000c0de 0 0 5 2 000000000004
1 1 0 00 1 00000000c0de 0 0 1 5 000000000004
1 1 0 00 1 00000000c0de 0 0 2 2 000000000004
1 0 0 00 1 00000000c0de 0 0 2 2 000000000004
1 0 0 00 1 00000000c0de 0 1 5 3 00000000c0de
1 0 0 00 0 000000000000 0 1 5 2 000000000005
// replay from id 2 after five beats
1 0 1 02 0 000000000000 0 0 5 2 000000000005
1 0 0 02 0 000000000000 0 0 4 6 000000000002
1 0 0 00 0 000000000000 0 0 3 3 fedcba987654
1 0 0 00 0 000000000000 0 0 3 4 5a5a5a5a5a5a
1 0 0 00 0 000000000000 0 0 3 3 00000000c0de
1 0 0 00 0 000000000000 0 0 3 2 000000000005
1 0 0 00 0 000000000000 0 1 5 2 000000000005
// retrans request while paused, replay from id 4
1 1 0 00 0 000000000000 0 0 5 2 000000000005
1 1 0 00 0 000000000000 0 0 1 5 000000000005
1 1 1 04 0 000000000000 0 0 2 2 000000000005
1 1 0 04 0 000000000000 0 0 4 6 000000000004
1 1 0 00 0 000000000000 0 0 3 3 00000000c0de
1 0 0 00 0 000000000000 0 0 3 2 000000000005
// alignment loss keeps next_id
1 0 0 00 1 800000000001 1 1 5 4 800000000001
0 0 0 00 0 000000000000 0 0 5 1 000000000006
0 0 0 00 0 000000000000 0 0 0 1 000000000006
1 0 0 00 0 000000000000 0 0 0 2 000000000006
1 0 0 00 0 000000000000 0 1 5 2 000000000006
// end marker
e 0 0 00 0 000000000000 0 0 0 0 000000000000

/* verification/tb_rifl_tx_lane.sv */
// drives the lane from a per-cycle trace and checks flags, tready and every frame
// a trace row holds inputs, the expected state and tready, and the frame due one cycle later
module tb_rifl_tx_lane
    import rifl_tx_pkg::*;
();
    localparam int CLK_HALF        = 5;
    localparam int RESET_CYCLES    = 10;
    localparam int RESET_TIMEOUT   = 20;
    localparam int TRACE_FIELDS    = 11;
    localparam int TRACE_MAX_LINES = 64;
    localparam logic [PAYLOAD_WIDTH-1:0] TRACE_END = 'he;

    logic      tx_frame_clk;
    logic      rst_n;
    logic      rx_aligned;
    logic      pause_request;
    logic      retrans_request;
    frame_id_t retrans_id;
    payload_t  s_axis_tdata;
    logic      s_axis_tlast;
    logic      s_axis_tvalid;
    logic      s_axis_tready;
    frame_t    tx_frame;
    logic      tx_state_init;
    logic      tx_state_send_pause;
    logic      tx_state_pause;
    logic      tx_state_send_retrans;
    logic      tx_state_retrans;
    logic      tx_state_normal;

    logic [PAYLOAD_WIDTH-1:0] trace_mem [0:TRACE_FIELDS*TRACE_MAX_LINES-1];

    rifl_tx_lane i_rifl_tx_lane (
        .tx_frame_clk          (tx_frame_clk),
        .rst_n                 (rst_n),
        .rx_aligned            (rx_aligned),
        .pause_request         (pause_request),
        .retrans_request       (retrans_request),
        .retrans_id            (retrans_id),
        .s_axis_tdata          (s_axis_tdata),
        .s_axis_tlast          (s_axis_tlast),
        .s_axis_tvalid         (s_axis_tvalid),
        .s_axis_tready         (s_axis_tready),
        .tx_frame              (tx_frame),
        .tx_state_init         (tx_state_init),
        .tx_state_send_pause   (tx_state_send_pause),
        .tx_state_pause        (tx_state_pause),
        .tx_state_send_retrans (tx_state_send_retrans),
        .tx_state_retrans      (tx_state_retrans),
        .tx_state_normal       (tx_state_normal)
    );

    bind rifl_tx_lane rifl_tx_lane_assert u_rifl_tx_lane_assert (
        .tx_frame_clk          (tx_frame_clk),
        .rst_n                 (rst_n),
        .s_axis_tready         (s_axis_tready),
        .tx_state_init         (tx_state_init),
        .tx_state_send_pause   (tx_state_send_pause),
        .tx_state_pause        (tx_state_pause),
        .tx_state_send_retrans (tx_state_send_retrans),
        .tx_state_retrans      (tx_state_retrans),
        .tx_state_normal       (tx_state_normal)
    );

    always begin
        #CLK_HALF tx_frame_clk = ~tx_frame_clk;
    end

    // remainder of body * x^12 divided by the generator polynomial
    function automatic logic [CRC_WIDTH-1:0] crc12_ref(
        input logic [FRAME_WIDTH-CRC_WIDTH-1:0] body
    );
        logic [FRAME_WIDTH-1:0] rem;
        rem = {body, {CRC_WIDTH{1'b0}}};
        for (int i = FRAME_WIDTH - 1; i >= CRC_WIDTH; i--) begin
            if (rem[i]) begin
                rem[i -: CRC_WIDTH+1] = rem[i -: CRC_WIDTH+1] ^ {1'b1, CRC_POLY};
            end
        end
        return rem[CRC_WIDTH-1:0];
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_state(input string name, input tx_state_t expected);
        logic [5:0] flags;
        tx_state_t  actual;
        flags = {tx_state_normal, tx_state_send_retrans, tx_state_retrans,
                 tx_state_pause, tx_state_send_pause, tx_state_init};
        if (!$onehot(flags)) begin
            abort_run($sformatf("%s: the state flags are not one-hot (%b)", name, flags));
        end
        actual = ST_INIT;
        if (flags[1]) actual = ST_SEND_PAUSE;
        if (flags[2]) actual = ST_PAUSE;
        if (flags[3]) actual = ST_RETRANS;
        if (flags[4]) actual = ST_SEND_RETRANS;
        if (flags[5]) actual = ST_NORMAL;
        if (actual !== expected) begin
            $display("ERR %s state: expected %s actual %s", name, expected.name(), actual.name());
            abort_run("wrong transmit state");
        end
    endtask

    task automatic check_ready(input string name, input bit expected);
        if (s_axis_tready !== expected) begin
            $display("ERR %s tready: expected %0b actual %0b", name, expected, s_axis_tready);
            abort_run("wrong s_axis_tready");
        end
    endtask

    task automatic check_code(input string name, input frame_code_t expected,
                              input frame_code_t actual);
        if (actual !== expected) begin
            $display("ERR %s code: expected %0h actual %0h", name, expected, actual);
            abort_run("wrong frame code");
        end
    endtask

    task automatic check_payload(input string name, input payload_t expected,
                                 input payload_t actual);
        if (actual !== expected) begin
            $display("ERR %s payload: expected %h actual %h", name, expected, actual);
            abort_run("wrong payload field");
        end
    endtask

    task automatic check_crc(input string name, input frame_t actual);
        logic [CRC_WIDTH-1:0] expected;
        expected = crc12_ref(actual[FRAME_WIDTH-1:CRC_WIDTH]);
        if (actual[CRC_WIDTH-1:0] !== expected) begin
            $display("ERR %s crc: expected %h actual %h", name, expected, actual[CRC_WIDTH-1:0]);
            abort_run("wrong frame crc");
        end
    endtask

    task automatic check_frame(input string name, input frame_code_t code, input payload_t field);
        check_code(name, code, frame_code_t'(tx_frame[FRAME_WIDTH-1 -: CODE_WIDTH]));
        check_payload(name, field, tx_frame[CRC_WIDTH +: PAYLOAD_WIDTH]);
        check_crc(name, tx_frame);
    endtask

    task automatic check_assertions();
        if (i_rifl_tx_lane.u_rifl_tx_lane_assert.fail_count != 0) begin
            abort_run("a concurrent assertion on the controller failed");
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1) begin
            if (cycles == RESET_TIMEOUT) begin
                abort_run("reset was not released in time");
            end
            @(negedge tx_frame_clk);
            cycles++;
        end
        check_state("reset", ST_INIT);
        check_ready("reset", 1'b0);
        check_frame("reset", frame_code_t'(0), '0);
    endtask

    task automatic drive_row(input int base);
        rx_aligned      <= trace_mem[base][0];
        pause_request   <= trace_mem[base+1][0];
        retrans_request <= trace_mem[base+2][0];
        retrans_id      <= frame_id_t'(trace_mem[base+3]);
        s_axis_tvalid   <= trace_mem[base+4][0];
        s_axis_tdata    <= trace_mem[base+5];
        s_axis_tlast    <= trace_mem[base+6][0];
    endtask

    // one row per clock and its frame one cycle later
    task automatic run_trace();
        int          line_idx;
        int          base;
        bit          done;
        bit          have_prev;
        int          prev_line;
        frame_code_t prev_code;
        payload_t    prev_payload;
        line_idx  = 0;
        done      = 1'b0;
        have_prev = 1'b0;
        prev_line = 0;
        prev_code = CODE_IDLE;
        prev_payload = '0;
        while (!done) begin
            if (line_idx >= TRACE_MAX_LINES) begin
                abort_run("trace end marker not reached within the line limit");
            end
            base = line_idx * TRACE_FIELDS;
            @(posedge tx_frame_clk);
            if (trace_mem[base] === TRACE_END) begin
                done = 1'b1;
            end else if ($isunknown(trace_mem[base])) begin
                abort_run($sformatf("trace row %0d is missing or unreadable", line_idx));
            end else begin
                drive_row(base);
            end
            @(negedge tx_frame_clk);
            if (have_prev) begin
                check_frame($sformatf("line %0d frame", prev_line), prev_code, prev_payload);
            end
            if (!done) begin
                check_state($sformatf("line %0d", line_idx), tx_state_t'(trace_mem[base+8][2:0]));
                check_ready($sformatf("line %0d", line_idx), trace_mem[base+7][0]);
                prev_line    = line_idx;
                prev_code    = frame_code_t'(trace_mem[base+9][CODE_WIDTH-1:0]);
                prev_payload = trace_mem[base+10];
                have_prev    = 1'b1;
            end
            check_assertions();
            line_idx++;
        end
    endtask

    initial begin
        tx_frame_clk    = 1'b0;
        rst_n           = 1'b0;
        rx_aligned      = 1'b0;
        pause_request   = 1'b0;
        retrans_request = 1'b0;
        retrans_id      = '0;
        s_axis_tdata    = '0;
        s_axis_tlast    = 1'b0;
        s_axis_tvalid   = 1'b0;
        $readmemh("verification/rifl_tx_trace.txt", trace_mem);
        repeat (RESET_CYCLES) @(posedge tx_frame_clk);
        rst_n <= 1'b1;
        wait_reset_release();
        run_trace();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule
